// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - riscv_pkg.sv
  - alu.sv
  - control_unit.sv
  - imm_gen.sv
  - reg_file.sv
  - riscv_core.sv
  - target: test
    files:
      - tb_riscv_core.sv

// ==== alu.sv ====
`timescale 1ns/100ps

module alu import riscv_pkg::*; (
    input  data_t   a,
    input  data_t   b,
    input  alu_op_e op,
    output data_t   result,
    output logic    zero
);

    // shift amount is the low five bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            // signed compare
            ALU_SLT:  result = data_t'($signed(a) < $signed(b));
            ALU_SLTU: result = data_t'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // sign bit fills from the left
            ALU_SRA:  result = data_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // beq/bne decide on this after the subtract
    assign zero = (result == '0);

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit import riscv_pkg::*; (
    input  data_t   instr,
    output ctrl_t   ctrl,
    output alu_op_e alu_op
);

    opcode_e    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // main decode
    always_comb begin
        // unknown opcode falls through as a nop
        ctrl = '0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BRANCH: begin
                // only beq and bne, other funct3 do nothing
                ctrl.branch = (funct3 == 3'b000) ? BR_EQ :
                              (funct3 == 3'b001) ? BR_NE : BR_NONE;
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = SRC_A_ZERO;
            end
            OP_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = SRC_A_PC;
            end
            OP_JAL: begin
                // rd gets the link address
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                ctrl.branch    = BR_JUMP;
            end
            default: ctrl = '0;
        endcase
    end

    // alu operation from funct3 and bit 30
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OP_R || opcode == OP_IMM) begin
            case (funct3)
                // addi has no subtract form
                3'b000:  alu_op = (opcode == OP_R && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (opcode == OP_BRANCH) begin
            alu_op = ALU_SUB;
        end
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen import riscv_pkg::*; (
    input  data_t instr,
    output data_t imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            // i format
            OP_IMM, OP_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
            // s format, split field
            OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // b format, bit 0 always zero
            OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            // u format
            OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
            // j format
            OP_JAL: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file import riscv_pkg::*; (
    input  logic       CLK,
    input  logic       RESET_N,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  data_t      wdata,
    input  logic       we,
    output data_t      rdata1,
    output data_t      rdata2
);

    data_t regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through so decode sees a same-cycle writeback
    assign rdata1 = (rs1 == 5'd0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

// ==== riscv_core.sv ====
`timescale 1ns/100ps

module riscv_core import riscv_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  data_t                idata,
    output logic [ADDR_SIZE-1:0] iaddr,
    output logic [ADDR_SIZE-1:0] daddr,
    input  data_t                ddata_r,
    output data_t                ddata_w,
    output logic                 mem_write,
    output logic                 mem_read
);

    // fetch
    data_t pc;
    data_t pc_plus4;
    data_t pc_next;

    // stage registers
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // decode
    ctrl_t   ctrl_id;
    alu_op_e alu_op_id;
    data_t   imm_id;
    data_t   rs1_data_id;
    data_t   rs2_data_id;

    // execute
    data_t alu_a;
    data_t alu_b;
    data_t alu_result_ex;
    logic  alu_zero_ex;

    // memory and writeback
    logic  take_branch;
    data_t wb_data;

    assign pc_plus4 = pc + 32'd4;
    // redirect only when the branch reaches memory
    assign pc_next  = take_branch ? ex_mem.branch_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // word address, upper bits zero
    assign iaddr = {2'b00, pc[ADDR_SIZE-1:2]};

    // instr 0 after reset decodes as a nop
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            if_id <= '0;
        end else begin
            if_id.instr    <= idata;
            if_id.pc       <= pc;
            if_id.pc_plus4 <= pc_plus4;
        end
    end

    control_unit u_control (
        .instr  (if_id.instr),
        .ctrl   (ctrl_id),
        .alu_op (alu_op_id)
    );

    imm_gen u_imm_gen (
        .instr (if_id.instr),
        .imm   (imm_id)
    );

    // write port driven from writeback
    reg_file u_reg_file (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (if_id.instr[19:15]),
        .rs2     (if_id.instr[24:20]),
        .rd      (mem_wb.rd),
        .wdata   (wb_data),
        .we      (mem_wb.ctrl.reg_write),
        .rdata1  (rs1_data_id),
        .rdata2  (rs2_data_id)
    );

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl     <= ctrl_id;
            id_ex.alu_op   <= alu_op_id;
            id_ex.rd       <= if_id.instr[11:7];
            id_ex.pc       <= if_id.pc;
            id_ex.pc_plus4 <= if_id.pc_plus4;
            id_ex.rs1_data <= rs1_data_id;
            id_ex.rs2_data <= rs2_data_id;
            id_ex.imm      <= imm_id;
        end
    end

    // operand a covers auipc and lui
    always_comb begin
        case (id_ex.ctrl.src_a)
            SRC_A_PC:   alu_a = id_ex.pc;
            SRC_A_ZERO: alu_a = '0;
            default:    alu_a = id_ex.rs1_data;
        endcase
    end

    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex.alu_op),
        .result (alu_result_ex),
        .zero   (alu_zero_ex)
    );

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl          <= id_ex.ctrl;
            ex_mem.rd            <= id_ex.rd;
            ex_mem.pc_plus4      <= id_ex.pc_plus4;
            ex_mem.alu_result    <= alu_result_ex;
            ex_mem.rs2_data      <= id_ex.rs2_data;
            // branch and jal target, pc relative
            ex_mem.branch_target <= id_ex.pc + id_ex.imm;
            ex_mem.zero          <= alu_zero_ex;
        end
    end

    // data port straight from ex_mem
    assign daddr     = {2'b00, ex_mem.alu_result[ADDR_SIZE-1:2]};
    assign ddata_w   = ex_mem.rs2_data;
    assign mem_write = ex_mem.ctrl.mem_write;
    assign mem_read  = ex_mem.ctrl.mem_read;

    // taken decision on the registered zero flag
    always_comb begin
        case (ex_mem.ctrl.branch)
            BR_EQ:   take_branch = ex_mem.zero;
            BR_NE:   take_branch = !ex_mem.zero;
            BR_JUMP: take_branch = 1'b1;
            default: take_branch = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.ctrl       <= ex_mem.ctrl;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.pc_plus4   <= ex_mem.pc_plus4;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= ddata_r;
        end
    end

    // link value is the jal's own pc_plus4
    always_comb begin
        case (mem_wb.ctrl.wb_sel)
            WB_MEM:  wb_data = mem_wb.mem_data;
            WB_LINK: wb_data = mem_wb.pc_plus4;
            default: wb_data = mem_wb.alu_result;
        endcase
    end

endmodule

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // data path width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] data_t;

    // base opcodes of the kept rv32i subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // zero encodings first so a cleared ctrl_t is a nop
    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JUMP} branch_e;
    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        src_a_e  src_a;
        wb_sel_e wb_sel;
        branch_e branch;
    } ctrl_t;

    // fetch to decode
    typedef struct packed {
        data_t instr;
        data_t pc;
        data_t pc_plus4;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        ctrl_t   ctrl;
        alu_op_e alu_op;
        logic [4:0] rd;
        data_t   pc;
        data_t   pc_plus4;
        data_t   rs1_data;
        data_t   rs2_data;
        data_t   imm;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        ctrl_t      ctrl;
        logic [4:0] rd;
        data_t      pc_plus4;
        data_t      alu_result;
        data_t      rs2_data;
        data_t      branch_target;
        logic       zero;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        ctrl_t      ctrl;
        logic [4:0] rd;
        data_t      pc_plus4;
        data_t      alu_result;
        data_t      mem_data;
    } mem_wb_t;

endpackage

// ==== tb.f ====
riscv_pkg.sv
alu.sv
control_unit.sv
imm_gen.sv
reg_file.sv
riscv_core.sv
tb_riscv_core.sv

// ==== tb_riscv_core.sv ====
`timescale 1ns/100ps

module tb_riscv_core import riscv_pkg::*; ();

    localparam int ADDR_SIZE = 12;
    localparam int WORDS     = 2 ** (ADDR_SIZE - 2);
    // random slots, then 32 dump slots, then the self-loop
    localparam int SLOTS     = 48;
    localparam int LOOP_WORD = 4 * (SLOTS + 32);
    localparam int DUMP_BASE = 1024;
    localparam int TIMEOUT   = 2000;

    typedef logic [ADDR_SIZE-1:0] waddr_t;

    logic   CLK;
    logic   RESET_N;
    data_t  idata;
    waddr_t iaddr;
    waddr_t daddr;
    data_t  ddata_r;
    data_t  ddata_w;
    logic   mem_write;
    logic   mem_read;

    // program as decoded fields with one entry per instruction word
    opcode_e    p_op  [WORDS];
    logic [2:0] p_f3  [WORDS];
    logic       p_alt [WORDS];
    logic [4:0] p_rd  [WORDS];
    logic [4:0] p_rs1 [WORDS];
    logic [4:0] p_rs2 [WORDS];
    data_t      p_imm [WORDS];

    data_t imem [WORDS];
    data_t dmem [WORDS];
    data_t model_mem [WORDS];

    // expected values per fetch cycle
    waddr_t q_iaddr [$];
    logic   q_we [$];
    logic   q_re [$];
    waddr_t q_daddr [$];
    data_t  q_wdata [$];

    riscv_core #(.ADDR_SIZE(ADDR_SIZE)) uut (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .idata     (idata),
        .iaddr     (iaddr),
        .daddr     (daddr),
        .ddata_r   (ddata_r),
        .ddata_w   (ddata_w),
        .mem_write (mem_write),
        .mem_read  (mem_read)
    );

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(data_t got, data_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(waddr_t got, waddr_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // byte address to memory word with the upper bits dropped
    function automatic waddr_t word_of(data_t byte_addr);
        return waddr_t'((byte_addr >> 2) % WORDS);
    endfunction

    // rv32i integer ops by funct3 with bit 30 as alt
    function automatic data_t compute_alu(logic [2:0] f3, logic alt, data_t a, data_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic data_t encode_instr(int w);
        data_t i;
        i = p_imm[w];
        case (p_op[w])
            OP_R:
                return {1'b0, p_alt[w], 5'b0, p_rs2[w], p_rs1[w], p_f3[w], p_rd[w], OP_R};
            OP_STORE:
                return {i[11:5], p_rs2[w], p_rs1[w], p_f3[w], i[4:0], OP_STORE};
            OP_BRANCH:
                return {i[12], i[10:5], p_rs2[w], p_rs1[w], p_f3[w], i[4:1], i[11], OP_BRANCH};
            OP_LUI, OP_AUIPC:
                return {i[31:12], p_rd[w], p_op[w]};
            OP_JAL:
                return {i[20], i[10:1], i[11], i[19:12], p_rd[w], OP_JAL};
            // i format including loads
            default:
                return {i[11:0], p_rs1[w], p_f3[w], p_rd[w], p_op[w]};
        endcase
    endfunction

    task automatic build_program();
        int w;
        int kind;
        int tgt;
        logic [11:0] imm12;
        // everything starts as addi x0, x0, 0
        for (int i = 0; i < WORDS; i++) begin
            p_op[i]  = OP_IMM;
            p_f3[i]  = 3'd0;
            p_alt[i] = 1'b0;
            p_rd[i]  = 5'd0;
            p_rs1[i] = 5'd0;
            p_rs2[i] = 5'd0;
            p_imm[i] = '0;
        end
        for (int s = 0; s < SLOTS; s++) begin
            w        = 4 * s;
            kind     = $urandom_range(0, 8);
            imm12    = 12'($urandom);
            tgt      = $urandom_range(s + 1, SLOTS);
            // every eighth slot aims at x0
            p_rd[w]  = (s % 8 == 7) ? 5'd0 : 5'($urandom_range(0, 31));
            p_rs1[w] = 5'($urandom_range(0, 31));
            p_rs2[w] = 5'($urandom_range(0, 31));
            p_f3[w]  = 3'($urandom_range(0, 7));
            p_imm[w] = {{20{imm12[11]}}, imm12};
            case (kind)
                0: begin
                    p_op[w] = OP_R;
                    if (p_f3[w] == 3'd0 || p_f3[w] == 3'd5) begin
                        p_alt[w] = 1'($urandom_range(0, 1));
                    end
                end
                1: begin
                    p_op[w] = OP_IMM;
                    // shift immediates keep only shamt and bit 30
                    if (p_f3[w] == 3'd5) begin
                        p_alt[w] = 1'($urandom_range(0, 1));
                    end
                    if (p_f3[w] == 3'd1 || p_f3[w] == 3'd5) begin
                        p_imm[w] = {21'b0, p_alt[w], 5'b0, imm12[4:0]};
                    end
                end
                2, 3: begin
                    p_op[w] = (kind == 2) ? OP_LOAD : OP_STORE;
                    p_f3[w] = 3'd2;
                end
                4, 5: begin
                    // beq or bne forward to a later slot
                    p_op[w]  = OP_BRANCH;
                    p_f3[w]  = 3'(kind - 4);
                    p_imm[w] = data_t'((tgt - s) * 16);
                end
                6, 7: begin
                    p_op[w]  = (kind == 6) ? OP_LUI : OP_AUIPC;
                    p_imm[w] = $urandom & 32'hffff_f000;
                end
                default: begin
                    p_op[w]  = OP_JAL;
                    p_imm[w] = data_t'((tgt - s) * 16);
                end
            endcase
        end
        // dump x0..x31 to distinct words
        for (int r = 0; r < 32; r++) begin
            w        = 4 * (SLOTS + r);
            p_op[w]  = OP_STORE;
            p_f3[w]  = 3'd2;
            p_rs2[w] = 5'(r);
            p_imm[w] = data_t'(DUMP_BASE + 4 * r);
        end
        // jal x0, 0
        p_op[LOOP_WORD] = OP_JAL;
        for (int i = 0; i < WORDS; i++) begin
            imem[i] = encode_instr(i);
        end
    endtask

    // sequential model with the three fall-through fetches after a taken jump
    task automatic run_model();
        data_t regs [32];
        data_t pc;
        data_t a;
        data_t b;
        data_t res;
        data_t target;
        logic  wr;
        logic  taken;
        int    w;
        int    countdown;
        int    stop_at;
        regs      = '{default: '0};
        pc        = '0;
        target    = '0;
        countdown = 0;
        stop_at   = -1;
        for (int k = 0; k < TIMEOUT; k++) begin
            w     = (pc >> 2) % WORDS;
            a     = regs[p_rs1[w]];
            b     = regs[p_rs2[w]];
            wr    = 1'b1;
            taken = 1'b0;
            res   = '0;
            q_iaddr.push_back(waddr_t'(w));
            q_we.push_back(p_op[w] == OP_STORE);
            q_re.push_back(p_op[w] == OP_LOAD);
            q_daddr.push_back(word_of(a + p_imm[w]));
            q_wdata.push_back(b);
            case (p_op[w])
                OP_R:     res = compute_alu(p_f3[w], p_alt[w], a, b);
                OP_IMM:   res = compute_alu(p_f3[w], p_alt[w], a, p_imm[w]);
                OP_LOAD:  res = model_mem[word_of(a + p_imm[w])];
                OP_STORE: begin
                    model_mem[word_of(a + p_imm[w])] = b;
                    wr = 1'b0;
                end
                OP_BRANCH: begin
                    wr    = 1'b0;
                    taken = (p_f3[w] == 3'd0) ? (a == b) : (a != b);
                end
                OP_LUI:   res = p_imm[w];
                OP_AUIPC: res = pc + p_imm[w];
                OP_JAL: begin
                    res   = pc + 4;
                    taken = 1'b1;
                end
                default:  wr = 1'b0;
            endcase
            // x0 stays zero
            if (wr && p_rd[w] != 5'd0) begin
                regs[p_rd[w]] = res;
            end
            if (countdown > 0) begin
                countdown--;
                pc = (countdown == 0) ? target : pc + 4;
            end else begin
                if (taken) begin
                    countdown = 3;
                    target    = pc + p_imm[w];
                end
                pc = pc + 4;
            end
            // follow the self-loop around twice
            if (stop_at < 0 && w == LOOP_WORD) begin
                stop_at = k + 9;
            end
            if (k == stop_at) begin
                break;
            end
        end
        if (stop_at < 0) begin
            abort_run("the model program never reached its final loop");
        end
    endtask

    task automatic compare_cycle(int k);
        check_addr(iaddr, q_iaddr[k], $sformatf("iaddr in cycle %0d", k));
        if (k < 3) begin
            // pipeline still empty after reset
            check_flag(mem_write, 1'b0, $sformatf("mem_write in cycle %0d", k));
            check_flag(mem_read, 1'b0, $sformatf("mem_read in cycle %0d", k));
        end else begin
            check_flag(mem_write, q_we[k-3], $sformatf("mem_write in cycle %0d", k));
            check_flag(mem_read, q_re[k-3], $sformatf("mem_read in cycle %0d", k));
            if (q_we[k-3]) begin
                check_addr(daddr, q_daddr[k-3], $sformatf("store daddr in cycle %0d", k));
                check_data(ddata_w, q_wdata[k-3], $sformatf("store data in cycle %0d", k));
            end
        end
    endtask

    initial begin
        int cycle;
        RESET_N = 1'b0;
        void'($urandom(67927));
        for (int i = 0; i < WORDS; i++) begin
            dmem[i]      = $urandom;
            model_mem[i] = dmem[i];
        end
        build_program();
        run_model();

        repeat (10) @(negedge CLK);
        RESET_N = 1'b1;

        // sample mid-cycle until the final loop is fetched
        cycle = 0;
        compare_cycle(cycle);
        while (iaddr !== waddr_t'(LOOP_WORD)) begin
            @(negedge CLK);
            cycle++;
            if (cycle >= TIMEOUT || cycle >= q_iaddr.size()) begin
                abort_run("timeout: the program never reached its final loop");
            end
            compare_cycle(cycle);
        end
        // self-loop fetch pattern
        while (cycle < q_iaddr.size() - 1) begin
            @(negedge CLK);
            cycle++;
            compare_cycle(cycle);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
